// ==== project.f ====
tensor_pkg.sv
tensor_fp_widen.sv
tensor_fp32_mul.sv
tensor_fp32_add.sv
tensor_mac.sv
tensor_wb_regs.sv
tensor_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_tensor_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_tensor_top -f project.f -o tb_tensor_top

./obj_dir/tb_tensor_top | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run_sim: testbench reported failure"
    exit 1
fi
echo "run_sim: no failure reported"

// ==== tb_checker.sv ====
// ********************
// testbench monitor: compares bus read data with the posted expected word
// ********************
module tb_checker
    import tensor_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_ack,
    input  logic        wb_we,
    input  logic [7:0]  wb_adr,
    input  logic [31:0] wb_dat_r,
    input  logic [31:0] exp_word,
    output int          errors,
    output int          checks
);

    function automatic string reg_name(input logic [2:0] idx);
        case (idx)
            reg_cmd:    return "reg_cmd";
            reg_a:      return "reg_a";
            reg_b:      return "reg_b";
            reg_acc:    return "reg_acc";
            reg_result: return "reg_result";
            reg_status: return "reg_status";
            default:    return "unmapped";
        endcase
    endfunction

    // the falling edge lies half a cycle away from every register update
    always @(negedge clk) begin
        if (reset) begin
            errors = 0;
            checks = 0;
        end else if (wb_ack && !wb_we) begin
            checks = checks + 1;
            if (wb_dat_r !== exp_word) begin
                errors = errors + 1;
                $display("mismatch at time %0t: %s read %08h, expected %08h",
                         $time, reg_name(wb_adr[4:2]), wb_dat_r, exp_word);
            end
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
// ********************
// testbench clock and reset generator
// ********************
module tb_clock_gen #(
    parameter int period       = 20,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset is released on a rising edge after the given number of cycles
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== tb_tensor_top.sv ====
// ********************
// testbench top: stimulus table, Wishbone driver tasks, watchdog and DUT
// ********************
module tb_tensor_top
    import tensor_pkg::*;
;

    localparam int clk_period        = 20;
    localparam int reset_cycles      = 10;
    localparam int clocks_per_access = 4;
    localparam int n_random          = 6;

    typedef struct packed {
        logic [7:0]  fmt;
        logic [7:0]  func;
        logic [1:0]  rm;
        logic        chain;
        logic        load_acc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
        logic [31:0] result;
        logic [4:0]  flags;
        logic [15:0] status;
    } entry_t;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [31:0] exp_word;
    logic [31:0] acc_model;
    logic        table_ready;
    int          errors;
    int          checks;
    int          reads_issued;
    int          seed;
    int          watchdog_limit;
    entry_t      table_q[$];

    tb_clock_gen #(
        .period       (clk_period),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    tensor_top #(
        .wb_addr_width (8)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    tb_checker u_checker (
        .clk      (clk),
        .reset    (reset),
        .wb_ack   (wb_ack),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_r (wb_dat_r),
        .exp_word (exp_word),
        .errors   (errors),
        .checks   (checks)
    );

    function automatic logic [7:0] reg_addr(input logic [2:0] idx);
        return {3'b000, idx, 2'b00};
    endfunction

    // small positive integers only, so the encoding is always exact
    function automatic logic [31:0] int_to_fp32(input int unsigned n);
        int          msb;
        logic [31:0] m;
        if (n == 0) begin
            return 32'h0;
        end
        msb = 0;
        for (int i = 0; i < 24; i++) begin
            if (n[i]) begin
                msb = i;
            end
        end
        m = n << (23 - msb);
        return {1'b0, 8'(127 + msb), m[22:0]};
    endfunction

    task automatic add_entry(input logic [7:0] fmt, input logic [7:0] func,
                             input logic [1:0] rm, input logic chain, input logic load_acc,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] acc, input logic [31:0] result,
                             input logic [4:0] flags, input logic [15:0] status);
        entry_t e;
        e = '{fmt, func, rm, chain, load_acc, a, b, acc, result, flags, status};
        table_q.push_back(e);
    endtask

    task automatic bus_write(input logic [2:0] idx, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_sel   <= 4'hf;
        wb_adr   <= reg_addr(idx);
        wb_dat_w <= data;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_read_check(input logic [2:0] idx, input logic [31:0] expected);
        @(posedge clk);
        reads_issued = reads_issued + 1;
        exp_word <= expected;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b0;
        wb_sel   <= 4'hf;
        wb_adr   <= reg_addr(idx);
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        bus_write(reg_a, e.a);
        bus_write(reg_b, e.b);
        if (e.load_acc) begin
            bus_write(reg_acc, e.acc);
            acc_model = e.acc;
        end
        bus_write(reg_cmd, {7'h0, e.chain, 6'h0, e.rm, e.fmt, e.func});
        // a chained command that was accepted leaves its result in acc
        if (e.chain && e.status == status_ok) begin
            acc_model = e.result;
        end
        bus_read_check(reg_result, e.result);
        bus_read_check(reg_status, {1'b0, 10'h0, e.flags, e.status});
        bus_read_check(reg_acc, acc_model);
    endtask

    task automatic build_table();
        int a_int;
        int b_int;
        int acc_int;
        // columns: fmt, func, rm, chain, load acc, a, b, acc, result, flags, status
        add_entry(fmt_binary32, func_gemm, rm_rne, 1'b0, 1'b1,
                  32'h3fc00000, 32'h40000000, 32'h3f000000, 32'h40600000, 5'h00, status_ok);
        add_entry(fmt_binary16, func_dot, rm_rne, 1'b0, 1'b1,
                  32'h00003e00, 32'h00004000, 32'h3f000000, 32'h40600000, 5'h00, status_ok);
        add_entry(fmt_bfloat16, func_gemm, rm_rne, 1'b0, 1'b1,
                  32'h00003fc0, 32'h00004000, 32'h3f000000, 32'h40600000, 5'h00, status_ok);
        add_entry(fmt_binary32, func_gemm, rm_rne, 1'b0, 1'b1,
                  32'h7f800001, 32'h3f800000, 32'h00000000, 32'h7fc00000, 5'h10, status_ok);
        add_entry(fmt_binary16, func_dot, rm_rne, 1'b0, 1'b1,
                  32'h00007c01, 32'h00003c00, 32'h00000000, 32'h7fc00000, 5'h10, status_ok);
        // 1 + 0.75 ulp under each rounding mode, then the negative mirror
        add_entry(fmt_binary32, func_sum, rm_rne, 1'b0, 1'b1,
                  32'h33c00000, 32'h00000000, 32'h3f800000, 32'h3f800001, 5'h01, status_ok);
        add_entry(fmt_binary32, func_sum, rm_rtz, 1'b0, 1'b1,
                  32'h33c00000, 32'h00000000, 32'h3f800000, 32'h3f800000, 5'h01, status_ok);
        add_entry(fmt_binary32, func_sum, rm_rdn, 1'b0, 1'b1,
                  32'h33c00000, 32'h00000000, 32'h3f800000, 32'h3f800000, 5'h01, status_ok);
        add_entry(fmt_binary32, func_sum, rm_rup, 1'b0, 1'b1,
                  32'h33c00000, 32'h00000000, 32'h3f800000, 32'h3f800001, 5'h01, status_ok);
        add_entry(fmt_binary32, func_sum, rm_rdn, 1'b0, 1'b1,
                  32'hb3c00000, 32'h00000000, 32'hbf800000, 32'hbf800001, 5'h01, status_ok);
        add_entry(fmt_binary32, func_sum, rm_rup, 1'b0, 1'b1,
                  32'hb3c00000, 32'h00000000, 32'hbf800000, 32'hbf800000, 5'h01, status_ok);
        // exact half ulp ties to the even neighbour
        add_entry(fmt_binary32, func_sum, rm_rne, 1'b0, 1'b1,
                  32'h33800000, 32'h00000000, 32'h3f800000, 32'h3f800000, 5'h01, status_ok);
        add_entry(fmt_binary32, func_gemm, rm_rne, 1'b0, 1'b1,
                  32'h7f7fffff, 32'h40000000, 32'h00000000, 32'h7f800000, 5'h05, status_ok);
        add_entry(fmt_binary32, func_gemm, rm_rtz, 1'b0, 1'b1,
                  32'h7f7fffff, 32'h40000000, 32'h00000000, 32'h7f7fffff, 5'h05, status_ok);
        add_entry(fmt_binary32, func_gemm, rm_rdn, 1'b0, 1'b1,
                  32'h7f7fffff, 32'h40000000, 32'h00000000, 32'h7f7fffff, 5'h05, status_ok);
        add_entry(fmt_binary32, func_gemm, rm_rup, 1'b0, 1'b1,
                  32'h7f7fffff, 32'h40000000, 32'h00000000, 32'h7f800000, 5'h05, status_ok);
        // SUM with a signalling NaN in b must stay clean
        add_entry(fmt_binary32, func_sum, rm_rne, 1'b0, 1'b1,
                  32'h40000000, 32'h7f800001, 32'h3f800000, 32'h40400000, 5'h00, status_ok);
        // chained dot product 1*2 + 3*0.5 + (-2)*0.25 = 3
        add_entry(fmt_binary32, func_dot, rm_rne, 1'b1, 1'b1,
                  32'h3f800000, 32'h40000000, 32'h00000000, 32'h40000000, 5'h00, status_ok);
        add_entry(fmt_binary32, func_dot, rm_rne, 1'b1, 1'b0,
                  32'h40400000, 32'h3f000000, 32'h00000000, 32'h40600000, 5'h00, status_ok);
        add_entry(fmt_binary32, func_dot, rm_rne, 1'b1, 1'b0,
                  32'hc0000000, 32'h3e800000, 32'h00000000, 32'h40400000, 5'h00, status_ok);
        add_entry(8'h07, func_gemm, rm_rne, 1'b1, 1'b1,
                  32'h3f800000, 32'h3f800000, 32'h12345678, 32'h12345678, 5'h00,
                  status_invalid_op);
        add_entry(fmt_binary32, 8'h09, rm_rne, 1'b0, 1'b1,
                  32'h7f800001, 32'h3f800000, 32'h3f800000, 32'h3f800000, 5'h00,
                  status_invalid_op);
        for (int i = 0; i < n_random; i++) begin
            a_int = i + 2;
            acc_int = 3 * i + 1;
            b_int = ($random(seed) & 15) + 1;
            add_entry(fmt_binary32, (i % 2 == 0) ? func_gemm : func_dot, rm_rne, 1'b0, 1'b1,
                      int_to_fp32(a_int), int_to_fp32(b_int), int_to_fp32(acc_int),
                      int_to_fp32(acc_int + a_int * b_int), 5'h00, status_ok);
        end
    endtask

    initial begin
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_sel       = 4'h0;
        wb_adr       = 8'h0;
        wb_dat_w     = 32'h0;
        exp_word     = 32'h0;
        acc_model    = 32'h0;
        reads_issued = 0;
        table_ready  = 1'b0;
        seed         = 32'h3e1b;
        build_table();
        table_ready = 1'b1;
        wait (reset === 1'b0);
        // out of reset the status is ok with busy clear, and holes read as zero
        bus_read_check(reg_status, 32'h0);
        bus_read_check(reg_result, 32'h0);
        bus_read_check(3'd6, 32'h0);
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        @(posedge clk);
        if (checks != reads_issued) begin
            $display("checker compared %0d reads but %0d reads were issued",
                     checks, reads_issued);
        end
        $display("%0d errors in %0d checked reads", errors, checks);
        if (errors == 0 && checks == reads_issued) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // every entry gets 20 bus accesses of at most 4 clocks each
    initial begin
        wait (table_ready);
        watchdog_limit = reset_cycles + table_q.size() * 20 * clocks_per_access;
        repeat (watchdog_limit) @(posedge clk);
        $display("timeout: the tests did not finish within %0d clock cycles", watchdog_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== tensor_fp32_add.sv ====
// ********************
// binary32 adder with four rounding modes and IEEE flags
// ********************
module tensor_fp32_add
    import tensor_pkg::*;
(
    input  logic [31:0]   x,
    input  logic [31:0]   y,
    input  tensor_rm_e    rm,
    output fp32_flagged_t sum
);

    logic              x_zero, y_zero;
    logic              x_inf, y_inf;
    logic              x_nan, y_nan;
    logic              snan;
    logic              swap;
    logic              eff_sub;
    logic [31:0]       big;
    logic [31:0]       small_op;
    logic [7:0]        diff;
    logic [53:0]       shifted;
    logic [26:0]       big_sig;
    logic [26:0]       small_sig;
    logic [27:0]       raw_sum;
    logic [26:0]       norm;
    logic [4:0]        lz;
    logic              found;
    logic signed [9:0] exp;

    assign x_zero  = x[30:23] == 8'h00;
    assign y_zero  = y[30:23] == 8'h00;
    assign x_inf   = x[30:23] == 8'hff && x[22:0] == 23'h0;
    assign y_inf   = y[30:23] == 8'hff && y[22:0] == 23'h0;
    assign x_nan   = x[30:23] == 8'hff && x[22:0] != 23'h0;
    assign y_nan   = y[30:23] == 8'hff && y[22:0] != 23'h0;
    assign snan    = (x_nan & ~x[22]) | (y_nan & ~y[22]);
    assign eff_sub = x[31] ^ y[31];

    // larger magnitude goes first so the difference is never negative
    assign swap     = y[30:0] > x[30:0];
    assign big      = swap ? y : x;
    assign small_op = swap ? x : y;
    assign diff     = big[30:23] - small_op[30:23];

    // three extra bits sit below the significand and shifted-out bits fold into a sticky lsb
    assign big_sig   = {1'b1, big[22:0], 3'b000};
    assign shifted   = {1'b1, small_op[22:0], 30'h0} >> ((diff > 8'd27) ? 8'd28 : diff);
    assign small_sig = {shifted[53:28], shifted[27] | (|shifted[26:0])};
    assign raw_sum   = eff_sub ? {1'b0, big_sig} - {1'b0, small_sig}
                               : {1'b0, big_sig} + {1'b0, small_sig};

    always_comb begin
        lz = 5'd0;
        found = 1'b0;
        for (int i = 26; i >= 0; i--) begin
            if (!found && raw_sum[i]) begin
                lz = 5'(26 - i);
                found = 1'b1;
            end
        end
        norm = raw_sum[26:0] << lz;
        if (raw_sum[27]) begin
            exp = 10'(big[30:23]) + 10'sd1;
        end else begin
            exp = 10'(big[30:23]) - 10'(lz);
        end
    end

    always_comb begin
        sum.v = fp32_qnan;
        sum.flags = '0;
        if (x_nan || y_nan) begin
            sum.flags[flag_invalid] = snan;
        end else if (x_inf && y_inf && eff_sub) begin
            sum.flags[flag_invalid] = 1'b1;
        end else if (x_inf || y_inf) begin
            sum.v = x_inf ? x : y;
        end else if (x_zero && y_zero) begin
            sum.v = {eff_sub ? (rm == rm_rdn) : x[31], 31'h0};
        end else if (x_zero) begin
            sum.v = y;
        end else if (y_zero) begin
            sum.v = x;
        end else if (raw_sum == 28'h0) begin
            // exact cancellation is +0 except when rounding down
            sum.v = {rm == rm_rdn, 31'h0};
        end else if (raw_sum[27]) begin
            sum = fp32_round_pack(big[31], exp, raw_sum[27:4], raw_sum[3], |raw_sum[2:0], rm);
        end else begin
            sum = fp32_round_pack(big[31], exp, norm[26:3], norm[2], |norm[1:0], rm);
        end
    end

endmodule

// ==== tensor_fp32_mul.sv ====
// ********************
// binary32 multiplier with four rounding modes and IEEE flags
// ********************
module tensor_fp32_mul
    import tensor_pkg::*;
(
    input  logic [31:0]   a,
    input  logic [31:0]   b,
    input  tensor_rm_e    rm,
    output fp32_flagged_t prod
);

    logic              sign;
    logic              a_zero, b_zero;
    logic              a_inf, b_inf;
    logic              a_nan, b_nan;
    logic              a_snan, b_snan;
    logic [47:0]       p;
    logic [47:0]       pn;
    logic signed [9:0] exp;

    assign sign   = a[31] ^ b[31];
    // subnormal inputs count as zero
    assign a_zero = a[30:23] == 8'h00;
    assign b_zero = b[30:23] == 8'h00;
    assign a_inf  = a[30:23] == 8'hff && a[22:0] == 23'h0;
    assign b_inf  = b[30:23] == 8'hff && b[22:0] == 23'h0;
    assign a_nan  = a[30:23] == 8'hff && a[22:0] != 23'h0;
    assign b_nan  = b[30:23] == 8'hff && b[22:0] != 23'h0;
    assign a_snan = a_nan & ~a[22];
    assign b_snan = b_nan & ~b[22];

    assign p = {1'b1, a[22:0]} * {1'b1, b[22:0]};

    // product of two normals lies in [1,4), move the leading one to bit 47
    assign pn  = p[47] ? p : (p << 1);
    assign exp = 10'(a[30:23]) + 10'(b[30:23]) - 10'sd127 + 10'(p[47]);

    always_comb begin
        prod.v = fp32_qnan;
        prod.flags = '0;
        if (a_nan || b_nan) begin
            prod.flags[flag_invalid] = a_snan | b_snan;
        end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            prod.flags[flag_invalid] = 1'b1;
        end else if (a_inf || b_inf) begin
            prod.v = {sign, 8'hff, 23'h0};
        end else if (a_zero || b_zero) begin
            prod.v = {sign, 31'h0};
        end else begin
            prod = fp32_round_pack(sign, exp, pn[47:24], pn[23], |pn[22:0], rm);
        end
    end

endmodule

// ==== tensor_fp_widen.sv ====
// ********************
// operand widener: binary16, bfloat16 or binary32 to binary32 with flags
// ********************
module tensor_fp_widen
    import tensor_pkg::*;
(
    input  tensor_fmt_e   fmt,
    input  logic [15:0]   raw,
    input  logic [31:0]   word,
    output fp32_flagged_t wide
);

    logic [31:0] cand;
    logic [4:0]  h_exp;

    assign h_exp = raw[14:10];

    always_comb begin
        // first place every format in binary32 bit positions
        case (fmt)
            fmt_binary16: begin
                if (h_exp == 5'd0) begin
                    cand = {raw[15], 31'h0};
                end else if (h_exp == 5'h1f) begin
                    cand = {raw[15], 8'hff, raw[9:0], 13'h0};
                end else begin
                    // rebias from 15 to 127
                    cand = {raw[15], 8'(h_exp) + 8'd112, raw[9:0], 13'h0};
                end
            end
            fmt_bfloat16: cand = {raw, 16'h0};
            default:      cand = word;
        endcase

        wide.v = cand;
        wide.flags = '0;
        if (cand[30:23] == 8'h00) begin
            wide.v = {cand[31], 31'h0};
        end else if (cand[30:23] == 8'hff && cand[22:0] != 23'h0) begin
            // quiet bit clear means a signalling NaN
            wide.v = fp32_qnan;
            wide.flags[flag_invalid] = ~cand[22];
        end
    end

endmodule

// ==== tensor_mac.sv ====
// ********************
// combinational MAC and reduction helper
// ********************
module tensor_mac
    import tensor_pkg::*;
(
    input  tensor_req_t req,
    output tensor_rsp_t rsp
);

    fp32_flagged_t a_w;
    fp32_flagged_t b_w;
    fp32_flagged_t prod;
    fp32_flagged_t sum;
    logic [31:0]   addend;
    logic          fmt_ok;
    logic          func_ok;
    logic          is_sum;

    tensor_fp_widen u_widen_a (
        .fmt  (req.cmd.fmt),
        .raw  (req.a[15:0]),
        .word (req.a),
        .wide (a_w)
    );

    tensor_fp_widen u_widen_b (
        .fmt  (req.cmd.fmt),
        .raw  (req.b[15:0]),
        .word (req.b),
        .wide (b_w)
    );

    tensor_fp32_mul u_mul (
        .a    (a_w.v),
        .b    (b_w.v),
        .rm   (req.cmd.rm),
        .prod (prod)
    );

    // SUM adds operand a directly and leaves b unused
    assign is_sum = req.cmd.func == func_sum;
    assign addend = is_sum ? a_w.v : prod.v;

    tensor_fp32_add u_add (
        .x   (req.acc),
        .y   (addend),
        .rm  (req.cmd.rm),
        .sum (sum)
    );

    assign fmt_ok = req.cmd.fmt inside {fmt_binary16, fmt_bfloat16, fmt_binary32};
    assign func_ok = req.cmd.func inside {func_gemm, func_dot, func_sum};

    always_comb begin
        rsp.result = req.acc;
        rsp.exc_flags = '0;
        rsp.status = status_invalid_op;
        if (fmt_ok && func_ok) begin
            rsp.result = sum.v;
            rsp.status = status_ok;
            rsp.exc_flags = a_w.flags | sum.flags;
            if (!is_sum) begin
                rsp.exc_flags = rsp.exc_flags | b_w.flags | prod.flags;
            end
        end
    end

    // an accepted command returns only the canonical quiet NaN, never a payload
    always_comb begin
        if (rsp.status == status_ok) begin
            assert (!(rsp.result[30:23] == 8'hff && rsp.result[22:0] != 23'h0)
                    || rsp.result == fp32_qnan);
        end
    end

endmodule

// ==== tensor_pkg.sv ====
// ********************
// tensor tier package: formats, opcodes, rounding modes, status codes,
// bus structs, register map and the shared binary32 round-and-pack function
// ********************
package tensor_pkg;

    typedef enum logic [7:0] {
        fmt_binary16 = 8'h01,
        fmt_bfloat16 = 8'h02,
        fmt_binary32 = 8'h03
    } tensor_fmt_e;

    typedef enum logic [7:0] {
        func_gemm = 8'h01,
        func_dot  = 8'h02,
        func_sum  = 8'h03
    } tensor_func_e;

    typedef enum logic [1:0] {
        rm_rne = 2'd0,
        rm_rtz = 2'd1,
        rm_rdn = 2'd2,
        rm_rup = 2'd3
    } tensor_rm_e;

    typedef enum logic [15:0] {
        status_ok         = 16'h0000,
        status_invalid_op = 16'h0001
    } tensor_status_e;

    // bit positions in the 5-bit exception field, divide-by-zero (bit 3) never fires
    localparam int flag_invalid   = 4;
    localparam int flag_overflow  = 2;
    localparam int flag_underflow = 1;
    localparam int flag_inexact   = 0;

    localparam logic [31:0] fp32_qnan = 32'h7fc0_0000;

    typedef struct packed {
        logic [31:0] v;
        logic [4:0]  flags;
    } fp32_flagged_t;

    typedef struct packed {
        tensor_func_e func;
        tensor_fmt_e  fmt;
        tensor_rm_e   rm;
        logic         chain;
    } tensor_cmd_t;

    typedef struct packed {
        tensor_cmd_t cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
    } tensor_req_t;

    typedef struct packed {
        logic [31:0]    result;
        logic [4:0]     exc_flags;
        tensor_status_e status;
    } tensor_rsp_t;

    // word index taken from bus address bits 4 to 2
    localparam logic [2:0] reg_cmd    = 3'd0;
    localparam logic [2:0] reg_a      = 3'd1;
    localparam logic [2:0] reg_b      = 3'd2;
    localparam logic [2:0] reg_acc    = 3'd3;
    localparam logic [2:0] reg_result = 3'd4;
    localparam logic [2:0] reg_status = 3'd5;

    // sig carries the hidden one in bit 23, exp is the biased exponent before rounding
    function automatic fp32_flagged_t fp32_round_pack(
        input logic              sign,
        input logic signed [9:0] exp,
        input logic [23:0]       sig,
        input logic              guard,
        input logic              sticky,
        input tensor_rm_e        rm
    );
        fp32_flagged_t     r;
        logic              lost;
        logic              inc;
        logic              to_inf;
        logic [24:0]       rsig;
        logic signed [9:0] rexp;

        lost = guard | sticky;
        case (rm)
            rm_rne:  inc = guard & (sticky | sig[0]);
            rm_rtz:  inc = 1'b0;
            rm_rdn:  inc = sign & lost;
            default: inc = ~sign & lost;
        endcase
        rsig = {1'b0, sig} + 25'(inc);
        rexp = exp;
        // a carry out of the significand bumps the exponent
        if (rsig[24]) begin
            rsig = rsig >> 1;
            rexp = exp + 10'sd1;
        end
        to_inf = (rm == rm_rne) || (rm == rm_rup && !sign) || (rm == rm_rdn && sign);
        r.flags = '0;
        r.flags[flag_inexact] = lost;
        if (rexp >= 10'sd255) begin
            r.v = to_inf ? {sign, 8'hff, 23'h0} : {sign, 8'hfe, 23'h7f_ffff};
            r.flags[flag_overflow] = 1'b1;
            r.flags[flag_inexact] = 1'b1;
        end else if (rexp <= 10'sd0) begin
            // no subnormal outputs, flush to signed zero
            r.v = {sign, 31'h0};
            r.flags[flag_underflow] = 1'b1;
            r.flags[flag_inexact] = 1'b1;
        end else begin
            r.v = {sign, rexp[7:0], rsig[22:0]};
        end
        return r;
    endfunction

endpackage

// ==== tensor_top.sv ====
// ********************
// tensor tier top: Wishbone register block and MAC helper
// ********************
module tensor_top
    import tensor_pkg::*;
#(
    parameter int wb_addr_width = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [3:0]               wb_sel,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [31:0]              wb_dat_w,
    output logic [31:0]              wb_dat_r,
    output logic                     wb_ack
);

    tensor_req_t req;
    tensor_rsp_t rsp;

    tensor_wb_regs #(
        .wb_addr_width (wb_addr_width)
    ) u_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .req      (req),
        .rsp      (rsp)
    );

    tensor_mac u_mac (
        .req (req),
        .rsp (rsp)
    );

endmodule

// ==== tensor_wb_regs.sv ====
// ********************
// Wishbone classic slave: operand, command, result and status registers
// ********************
module tensor_wb_regs
    import tensor_pkg::*;
#(
    parameter int wb_addr_width = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  logic [3:0]               wb_sel,
    input  logic [wb_addr_width-1:0] wb_adr,
    input  logic [31:0]              wb_dat_w,
    output logic [31:0]              wb_dat_r,
    output logic                     wb_ack,
    output tensor_req_t              req,
    input  tensor_rsp_t              rsp
);

    typedef enum logic {
        st_idle,
        st_exec
    } state_e;

    state_e         state;
    tensor_cmd_t    cmd_q;
    logic [31:0]    a_q;
    logic [31:0]    b_q;
    logic [31:0]    acc_q;
    logic [31:0]    result_q;
    logic [4:0]     flags_q;
    tensor_status_e status_q;
    logic [2:0]     reg_idx;
    logic           access;
    logic           full_word;
    logic [31:0]    rd_data;

    assign reg_idx = wb_adr[4:2];
    // the !wb_ack term keeps a held strobe from being acknowledged twice
    assign access = wb_cyc && wb_stb && !wb_ack && (state == st_idle);
    assign full_word = wb_sel == 4'hf;

    assign req.cmd = cmd_q;
    assign req.a   = a_q;
    assign req.b   = b_q;
    assign req.acc = acc_q;

    always_comb begin
        case (reg_idx)
            reg_cmd:    rd_data = {7'h0, cmd_q.chain, 6'h0, cmd_q.rm, cmd_q.fmt, cmd_q.func};
            reg_a:      rd_data = a_q;
            reg_b:      rd_data = b_q;
            reg_acc:    rd_data = acc_q;
            reg_result: rd_data = result_q;
            reg_status: rd_data = {state == st_exec, 10'h0, flags_q, status_q};
            default:    rd_data = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            wb_ack   <= 1'b0;
            wb_dat_r <= 32'h0;
            cmd_q    <= '0;
            a_q      <= 32'h0;
            b_q      <= 32'h0;
            acc_q    <= 32'h0;
            result_q <= 32'h0;
            flags_q  <= 5'h0;
            status_q <= status_ok;
        end else begin
            wb_ack <= access;
            if (access && !wb_we) begin
                wb_dat_r <= rd_data;
            end
            if (access && wb_we && full_word) begin
                case (reg_idx)
                    reg_cmd: begin
                        cmd_q.func  <= tensor_func_e'(wb_dat_w[7:0]);
                        cmd_q.fmt   <= tensor_fmt_e'(wb_dat_w[15:8]);
                        cmd_q.rm    <= tensor_rm_e'(wb_dat_w[17:16]);
                        cmd_q.chain <= wb_dat_w[24];
                        state       <= st_exec;
                    end
                    reg_a:   a_q <= wb_dat_w;
                    reg_b:   b_q <= wb_dat_w;
                    reg_acc: acc_q <= wb_dat_w;
                    default: begin
                    end
                endcase
            end
            // one cycle to let the MAC settle on the new command, then capture
            if (state == st_exec) begin
                result_q <= rsp.result;
                flags_q  <= rsp.exc_flags;
                status_q <= rsp.status;
                if (cmd_q.chain && rsp.status == status_ok) begin
                    acc_q <= rsp.result;
                end
                state <= st_idle;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb));
    assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack);

endmodule
